// File: verilog/nes_bus_pkg.sv
/*
 * Shared definitions for the console bus model.
 * Holds the bus widths, the two DMA register addresses, the master clock
 * divider counts and the packed structs that carry each bus between blocks.
 * Modules refer to these by scoped name, nes_bus_pkg::name.
 */
package nes_bus_pkg;

	// Bus widths
	localparam int cpu_addr_width = 16;
	localparam int mem_addr_width = 22;	// External memory, CPU and PPU share it
	localparam int chr_addr_width = 14;
	localparam int data_width = 8;

	// Register addresses seen by sprite DMA
	localparam logic [cpu_addr_width-1:0] sprite_dma_reg = 16'h4014;	// Write starts sprite DMA
	localparam logic [cpu_addr_width-1:0] oam_data_reg = 16'h2004;	// OAM data port

	// Master clocks per CPU cycle and per PPU cycle (NTSC)
	localparam int cpu_div_count = 12;
	localparam int ppu_div_count = 4;
	localparam int cpu_div_width = $clog2(cpu_div_count);
	localparam int ppu_div_width = $clog2(ppu_div_count);
	localparam logic [cpu_div_width-1:0] cpu_div_last = cpu_div_width'(cpu_div_count - 1);
	localparam logic [ppu_div_width-1:0] ppu_div_last = ppu_div_width'(ppu_div_count - 1);

	// Sprite DMA states, bit 0 pauses the CPU and bit 1 owns the bus
	localparam logic [1:0] spr_idle = 2'b00;
	localparam logic [1:0] spr_pending = 2'b01;	// Waiting for alignment or after a DMC steal
	localparam logic [1:0] spr_active = 2'b11;

	// Bus as driven by a master, CPU side or after DMA
	typedef struct packed {
		logic [cpu_addr_width-1:0] addr;
		logic [data_width-1:0] data;	// Write data
		logic rnw;	// 1 read, 0 write
		logic req;	// Access in this CPU cycle, idle bus when low
	} cpu_bus_t;

	// Request to the external memory
	typedef struct packed {
		logic [mem_addr_width-1:0] addr;
		logic [data_width-1:0] data;
		logic read_cpu;	// Result goes to the CPU data latch
		logic read_ppu;	// Result goes to the PPU data latch
		logic write;
	} mem_req_t;

	// PPU character port
	typedef struct packed {
		logic [chr_addr_width-1:0] addr;
		logic [data_width-1:0] data;
		logic read;
		logic write;
	} chr_req_t;

	// DMC sample fetch request, held until acknowledged
	typedef struct packed {
		logic req;
		logic [cpu_addr_width-1:0] addr;
	} dmc_req_t;

endpackage

// File: verilog/cpu_clock_divider.sv
/*
 * Master clock divider.
 * Produces single-clock CPU and PPU enables and the even/odd APU cycle flag.
 * Both counters restart on reset so every CPU enable lands on a PPU enable,
 * which the memory multiplex relies on.
 */
module cpu_clock_divider (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,	// One clock in cpu_div_count
	output logic ppu_ce,	// One clock in ppu_div_count
	output logic odd_cycle	// Parity of the current CPU cycle, low = even
);

	logic [nes_bus_pkg::cpu_div_width-1:0] cpu_count;
	logic [nes_bus_pkg::ppu_div_width-1:0] ppu_count;

	// Enables fire on the last count of each period
	assign cpu_ce = (cpu_count == nes_bus_pkg::cpu_div_last);
	assign ppu_ce = (ppu_count == nes_bus_pkg::ppu_div_last);

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_count <= '0;
			ppu_count <= '0;
			odd_cycle <= 1'b0;	// First CPU cycle is even
		end else begin
			cpu_count <= cpu_ce ? '0 : cpu_count + 1'b1;	// Wrap at period end
			ppu_count <= ppu_ce ? '0 : ppu_count + 1'b1;

			// APU cycle flips once per CPU cycle
			if (cpu_ce)
				odd_cycle <= !odd_cycle;
		end
	end

endmodule

// File: verilog/dma_controller.sv
/*
 * Sprite (OAM) and DMC DMA controller, and master select for the system bus.
 * A CPU write to the sprite DMA register starts a 256 byte copy from that page
 * to the OAM data port: reads on even cycles, writes on odd cycles.
 * A DMC request steals one even cycle for a sample fetch; the odd cycle after
 * it stays idle. All state advances on cpu_ce; the bus request leaving this
 * block is a one-clock strobe on cpu_ce.
 */
module dma_controller (
	input  logic clk,
	input  logic reset,
	input  logic cpu_ce,
	input  logic odd_cycle,
	input  nes_bus_pkg::cpu_bus_t cpu_bus,	// Access the CPU wants this cycle
	input  nes_bus_pkg::dmc_req_t dmc,
	input  logic [nes_bus_pkg::data_width-1:0] mem_din_cpu,	// CPU read data from memory
	output nes_bus_pkg::cpu_bus_t sys_bus,	// Bus after DMA
	output logic dmc_ack,
	output logic pause_cpu
);

	logic dmc_state;	// DMC fetch taken, runs on next even cycle
	logic [1:0] spr_state;
	logic [nes_bus_pkg::cpu_addr_width-1:0] spr_addr;	// Page and low byte counter
	logic [nes_bus_pkg::data_width:0] spr_next;	// Low byte plus carry out
	logic [nes_bus_pkg::data_width-1:0] byte_latch;	// Byte read for the next OAM write
	logic sprite_trigger;
	logic cpu_read;

	// An idle CPU counts as reading; only a write cycle holds off the DMC
	assign cpu_read = cpu_bus.rnw || !cpu_bus.req;

	// Completed write to the sprite DMA register
	assign sprite_trigger = sys_bus.req && !sys_bus.rnw &&
		(sys_bus.addr == nes_bus_pkg::sprite_dma_reg);

	assign spr_next = {1'b0, spr_addr[nes_bus_pkg::data_width-1:0]} + 1'b1;

	assign dmc_ack = dmc_state && !odd_cycle;	// Fetch cycle

	// A pending CPU write may still finish before the DMC gets the bus,
	// as with the 6502 RDY line
	assign pause_cpu = spr_state[0] || dmc_state || (dmc.req && cpu_read);

	// Control state
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= nes_bus_pkg::spr_idle;
		end else if (cpu_ce) begin
			// DMC is taken at the end of an even read cycle
			if (!dmc_state && dmc.req && cpu_read && !odd_cycle)
				dmc_state <= 1'b1;
			else if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;	// Fetch done

			if (sprite_trigger) begin
				spr_state <= nes_bus_pkg::spr_pending;
			end else if (spr_state == nes_bus_pkg::spr_pending && odd_cycle) begin
				spr_state <= nes_bus_pkg::spr_active;	// Next cycle is an even read
			end else if (spr_state == nes_bus_pkg::spr_active) begin
				if (!odd_cycle && dmc_state)
					spr_state <= nes_bus_pkg::spr_pending;	// DMC stole this read, retry
				else if (odd_cycle && spr_next[nes_bus_pkg::data_width])
					spr_state <= nes_bus_pkg::spr_idle;	// Last write done
			end
		end
	end

	// Source address, page from the CPU write data
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				spr_addr <= {sys_bus.data, {nes_bus_pkg::data_width{1'b0}}};
			else if (spr_state == nes_bus_pkg::spr_active && odd_cycle)
				spr_addr[nes_bus_pkg::data_width-1:0] <=
					spr_next[nes_bus_pkg::data_width-1:0];	// Advance after each write
		end
	end

	// Read data comes back during the write cycle that follows the read,
	// so keep tracking it until that cycle ends
	always_ff @(posedge clk) begin
		if (spr_state == nes_bus_pkg::spr_active && odd_cycle)
			byte_latch <= mem_din_cpu;
	end

	// Bus master select; DMC fetch has priority over the sprite read
	always_comb begin
		sys_bus = cpu_bus;
		sys_bus.req = cpu_ce && cpu_bus.req && !pause_cpu;	// Paused CPU stays off the bus
		if (dmc_ack) begin
			sys_bus.addr = dmc.addr;
			sys_bus.data = byte_latch;
			sys_bus.rnw = 1'b1;
			sys_bus.req = cpu_ce;
		end else if (spr_state == nes_bus_pkg::spr_active) begin
			sys_bus.addr = odd_cycle ? nes_bus_pkg::oam_data_reg : spr_addr;
			sys_bus.data = byte_latch;	// Byte from the previous read
			sys_bus.rnw = !odd_cycle;
			sys_bus.req = cpu_ce;
		end
	end

endmodule

// File: verilog/memory_multiplex.sv
/*
 * Shares one external memory between the system bus and the PPU port.
 * The PPU always wins and is issued on the ppu_ce where it is presented.
 * A CPU access arrives as a strobe on cpu_ce, which falls on a ppu_ce; if the
 * PPU is busy it is saved and issued on the next ppu_ce with the PPU idle.
 * Both addresses are zero-extended to the memory width.
 */
module memory_multiplex (
	input  logic clk,
	input  logic reset,
	input  logic ppu_ce,
	input  nes_bus_pkg::cpu_bus_t sys_bus,
	input  nes_bus_pkg::chr_req_t chr,
	output nes_bus_pkg::mem_req_t mem
);

	logic saved_read;
	logic saved_write;
	logic [nes_bus_pkg::cpu_addr_width-1:0] saved_addr;
	logic [nes_bus_pkg::data_width-1:0] saved_data;
	logic chr_busy;
	logic pending;	// Deferred CPU access waiting
	logic cpu_issue;
	logic cpu_is_read;
	logic [nes_bus_pkg::cpu_addr_width-1:0] cpu_addr;
	logic [nes_bus_pkg::data_width-1:0] cpu_data;
	logic cpu_defer;

	assign chr_busy = chr.read || chr.write;
	assign pending = saved_read || saved_write;

	// Oldest CPU access goes first
	assign cpu_addr = pending ? saved_addr : sys_bus.addr;
	assign cpu_data = pending ? saved_data : sys_bus.data;
	assign cpu_is_read = pending ? saved_read : sys_bus.rnw;
	assign cpu_issue = ppu_ce && !chr_busy && (pending || sys_bus.req);

	// New access that cannot go out now; a PPU busy for three ppu_ce in a row
	// would overwrite an older saved access, the PPU never does that
	assign cpu_defer = ppu_ce && sys_bus.req && (chr_busy || pending);

	always_comb begin
		mem = '0;
		if (chr_busy) begin
			mem.addr = {{(nes_bus_pkg::mem_addr_width - nes_bus_pkg::chr_addr_width){1'b0}},
				chr.addr};
			mem.data = chr.data;
			mem.read_ppu = ppu_ce && chr.read;
			mem.write = ppu_ce && chr.write;
		end else begin
			mem.addr = {{(nes_bus_pkg::mem_addr_width - nes_bus_pkg::cpu_addr_width){1'b0}},
				cpu_addr};
			mem.data = cpu_data;
			mem.read_cpu = cpu_issue && cpu_is_read;
			mem.write = cpu_issue && !cpu_is_read;
		end
	end

	// Saved flags
	always_ff @(posedge clk) begin
		if (reset) begin
			saved_read <= 1'b0;
			saved_write <= 1'b0;
		end else if (cpu_defer) begin
			saved_read <= sys_bus.rnw;
			saved_write <= !sys_bus.rnw;
		end else if (ppu_ce && !chr_busy) begin
			saved_read <= 1'b0;	// Saved access went out this cycle
			saved_write <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_defer) begin
			saved_addr <= sys_bus.addr;
			saved_data <= sys_bus.data;
		end
	end

endmodule

// File: verilog/nes_bus_top.sv
/*
 * Top level of the console bus model.
 * The clock divider paces everything, the DMA controller decides who masters
 * the system bus, and the multiplex merges that bus with the PPU port onto
 * the external memory. CPU, PPU and DMC sit outside as ports.
 */
module nes_bus_top (
	input  logic clk,
	input  logic reset,
	input  nes_bus_pkg::cpu_bus_t cpu_bus,	// CPU access, held while paused
	input  nes_bus_pkg::dmc_req_t dmc,
	input  nes_bus_pkg::chr_req_t chr,	// PPU character access
	input  logic [nes_bus_pkg::data_width-1:0] mem_din_cpu,	// CPU latch data from memory
	output nes_bus_pkg::mem_req_t mem,
	output logic dmc_ack,
	output logic pause_cpu,
	output logic cpu_ce
);

	logic ppu_ce;
	logic odd_cycle;
	nes_bus_pkg::cpu_bus_t sys_bus;	// Bus after DMA, strobed on cpu_ce

	cpu_clock_divider u_clock_divider (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.odd_cycle (odd_cycle)
	);

	dma_controller u_dma (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.odd_cycle   (odd_cycle),
		.cpu_bus     (cpu_bus),
		.dmc         (dmc),
		.mem_din_cpu (mem_din_cpu),
		.sys_bus     (sys_bus),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu)
	);

	// PPU side runs on the PPU enable
	memory_multiplex u_mem_mux (
		.clk     (clk),
		.reset   (reset),
		.ppu_ce  (ppu_ce),
		.sys_bus (sys_bus),
		.chr     (chr),
		.mem     (mem)
	);

endmodule

// File: tests/nes_bus_properties.sv
/*
 * Bound checks on the DMA and memory multiplex handshakes.
 * One instance sits in dma_controller and one in memory_multiplex; ports
 * that do not exist in a given scope are tied low.
 * The failures count is read by the testbench for its verdict.
 */
module nes_bus_properties (
	input  logic clk,
	input  logic reset,
	input  logic cpu_ce,
	input  logic dmc_ack,
	input  logic pause_cpu,
	input  logic bus_owned,	// System bus access the CPU did not ask for
	input  nes_bus_pkg::mem_req_t mem
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	// DMC acknowledge ends with the CPU cycle that carries the fetch
	dmc_ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		(dmc_ack && cpu_ce) |=> !dmc_ack)
		else begin
			failures++;
			$error("dmc_ack stayed high after its fetch cycle");
		end

	dmc_ack_ends_on_ce: assert property (@(posedge clk) disable iff (reset)
		$fell(dmc_ack) |-> $past(cpu_ce))
		else begin
			failures++;
			$error("dmc_ack fell away from a CPU enable");
		end

	// One strobe at a time so the CPU and PPU read latches never load together
	strobe_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({mem.read_cpu, mem.read_ppu, mem.write}))
		else begin
			failures++;
			$error("more than one memory strobe high");
		end

	owned_means_paused: assert property (@(posedge clk) disable iff (reset)
		bus_owned |-> pause_cpu)
		else begin
			failures++;
			$error("DMA owns the bus while the CPU runs");
		end

endmodule

bind dma_controller nes_bus_properties dma_props (
	.clk       (clk),
	.reset     (reset),
	.cpu_ce    (cpu_ce),
	.dmc_ack   (dmc_ack),
	.pause_cpu (pause_cpu),
	.bus_owned (sys_bus.req && (!cpu_bus.req || sys_bus.addr != cpu_bus.addr ||
		sys_bus.rnw != cpu_bus.rnw)),
	.mem       ('0)
);

bind memory_multiplex nes_bus_properties mux_props (
	.clk       (clk),
	.reset     (reset),
	.cpu_ce    (1'b0),
	.dmc_ack   (1'b0),
	.pause_cpu (1'b0),
	.bus_owned (1'b0),
	.mem       (mem)
);

// File: tests/nes_bus_tb.sv
/*
 * Testbench for the console bus model.
 * Acts as CPU, PPU, DMC and external memory around nes_bus_top, logs every
 * memory strobe and checks reset quiet time, plain CPU accesses, sprite DMA
 * with and without a DMC steal, and PPU collisions.
 */
module nes_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam longint watchdog_ns = (3 * 516 * 12 + 4000) * 20;	// 3 sprite copies plus margin

	logic clk = 1'b0;
	logic reset;
	nes_bus_pkg::cpu_bus_t cpu_bus;
	nes_bus_pkg::dmc_req_t dmc;
	nes_bus_pkg::chr_req_t chr;
	logic [7:0] mem_din_cpu;
	nes_bus_pkg::mem_req_t mem;
	logic dmc_ack;
	logic pause_cpu;
	logic cpu_ce;

	int seed = 32'h808d;
	int errors = 0;
	nes_bus_pkg::mem_req_t log_q[$];	// Every strobed memory request
	logic [21:0] read_addr;
	logic read_seen = 1'b0;
	logic sprite_on = 1'b0;
	logic [7:0] page;
	int read_idx;
	int oam_idx;
	int dmc_count;

	nes_bus_top uut (
		.clk         (clk),
		.reset       (reset),
		.cpu_bus     (cpu_bus),
		.dmc         (dmc),
		.chr         (chr),
		.mem_din_cpu (mem_din_cpu),
		.mem         (mem),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu),
		.cpu_ce      (cpu_ce)
	);

	always #10 clk = ~clk;

	// Memory contents, a hash over every address bit
	function automatic logic [7:0] mem_byte(input logic [21:0] addr);
		return 8'(addr[7:0] * 8'h1d + addr[15:8] * 8'h3b + addr[21:16]) ^ 8'h5a;
	endfunction

	function automatic bit cpu_match(input nes_bus_pkg::mem_req_t m, input logic [15:0] addr,
		input logic [7:0] data, input logic rnw);
		return m.addr == {6'b0, addr} && m.read_cpu == rnw && m.write == !rnw &&
			!m.read_ppu && (rnw || m.data == data);
	endfunction

	function automatic bit ppu_match(input nes_bus_pkg::mem_req_t m,
		input nes_bus_pkg::chr_req_t c);
		return m.addr == {8'b0, c.addr} && m.read_ppu == c.read && m.write == c.write &&
			!m.read_cpu && (!c.write || m.data == c.data);
	endfunction

	// Memory model, data driven on the falling edge after the read
	always @(negedge clk) begin
		if (read_seen)
			mem_din_cpu = mem_byte(read_addr);
		read_seen = 1'b0;
	end

	// Compare process: logs strobes, checks DMC fetches and sprite traffic
	always @(posedge clk) begin
		if (!reset && (mem.read_cpu || mem.read_ppu || mem.write))
			log_q.push_back(mem);
		if (mem.read_cpu) begin
			read_addr = mem.addr;
			read_seen = 1'b1;
		end
		if (dmc_ack && cpu_ce) begin
			dmc_count++;
			assert (mem.read_cpu && mem.addr == {6'b0, dmc.addr}) else begin
				errors++;
				$display("ERROR %0t: DMC fetch read %h, expected %h", $time, mem.addr, dmc.addr);
			end
		end else if (sprite_on && mem.read_cpu) begin
			assert (mem.addr == {6'b0, page, 8'(read_idx)} && read_idx < 256) else begin
				errors++;
				$display("ERROR %0t: sprite read %h, expected index %0d", $time, mem.addr, read_idx);
			end
			read_idx++;
		end
		if (sprite_on && mem.write && mem.addr == {6'b0, nes_bus_pkg::oam_data_reg}) begin
			assert (mem.data == mem_byte({6'b0, page, 8'(oam_idx)}) && read_idx == oam_idx + 1)
				else begin
					errors++;
					$display("ERROR %0t: OAM write %0d carries %h", $time, oam_idx, mem.data);
				end
			oam_idx++;
		end
	end

	task automatic wait_cpu_ce();	// Returns on a negedge whose next posedge has cpu_ce
		@(negedge clk);
		while (!cpu_ce)
			@(negedge clk);
	endtask

	// CPU access, held until a CPU cycle takes it
	task automatic cpu_access(input logic [15:0] addr, input logic [7:0] data, input logic rnw);
		cpu_bus = '{addr: addr, data: data, rnw: rnw, req: 1'b1};
		while (!(cpu_ce && !pause_cpu))
			@(negedge clk);
		@(negedge clk);
		cpu_bus.req = 1'b0;
	endtask

	task automatic random_access();
		logic [15:0] addr;
		logic [7:0] data;
		logic rnw;
		int base;
		addr = $random(seed);
		data = $random(seed);
		rnw = $random(seed);
		if (addr == nes_bus_pkg::sprite_dma_reg)
			addr[0] = 1'b1;
		base = log_q.size();
		cpu_access(addr, data, rnw);
		assert (log_q.size() == base + 1 && cpu_match(log_q[base], addr, data, rnw)) else begin
			errors++;
			$display("ERROR %0t: CPU access to %h not seen on memory", $time, addr);
		end
	endtask

	task automatic sprite_copy(input bit steal);
		page = $random(seed);
		read_idx = 0;
		oam_idx = 0;
		dmc_count = 0;
		sprite_on = 1'b1;
		fork
			begin
				cpu_access(nes_bus_pkg::sprite_dma_reg, page, 1'b0);
				while (pause_cpu)
					@(negedge clk);
				// CPU may run again only after the last OAM write
				assert (read_idx == 256 && oam_idx == 256) else begin
					errors++;
					$display("ERROR %0t: pause ended after %0d reads, %0d writes",
						$time, read_idx, oam_idx);
				end
			end
			if (steal) begin
				repeat (1200) @(negedge clk);
				dmc = '{req: 1'b1, addr: 16'hc000 | 16'($random(seed))};
				while (!dmc_ack)
					@(negedge clk);
				dmc.req = 1'b0;
			end
		join
		sprite_on = 1'b0;
		assert (dmc_count == int'(steal)) else begin
			errors++;
			$display("ERROR %0t: %0d DMC acks, expected %0d", $time, dmc_count, steal);
		end
	endtask

	// PPU hits the CPU's slot, optionally the next PPU slot too
	task automatic ppu_collision(input bit two_slots);
		nes_bus_pkg::chr_req_t first;
		nes_bus_pkg::chr_req_t second;
		logic [15:0] addr;
		logic [7:0] data;
		logic rnw;
		int base;
		first = '{addr: 14'($random(seed)), data: 8'($random(seed)), read: 1'b0, write: 1'b0};
		first.read = $random(seed);
		first.write = !first.read;
		second = '{addr: 14'($random(seed)), data: 8'($random(seed)), read: 1'b1, write: 1'b0};
		addr = 16'($random(seed)) & 16'h3fff;	// Keeps clear of the DMA register
		data = $random(seed);
		rnw = $random(seed);
		wait_cpu_ce();
		base = log_q.size();
		cpu_bus = '{addr: addr, data: data, rnw: rnw, req: 1'b1};
		chr = first;
		@(negedge clk);
		cpu_bus.req = 1'b0;
		chr = '0;
		if (two_slots) begin
			repeat (3) @(negedge clk);
			chr = second;	// Next ppu_ce
			@(negedge clk);
			chr = '0;
		end
		repeat (12) @(negedge clk);
		assert (log_q.size() == base + 2 + two_slots && ppu_match(log_q[base], first) &&
			(!two_slots || ppu_match(log_q[base + 1], second)) &&
			cpu_match(log_q[base + 1 + two_slots], addr, data, rnw)) else begin
			errors++;
			$display("ERROR %0t: collision at CPU address %h issued wrongly", $time, addr);
		end
	endtask

	initial begin
		int n;
		int failures;
		reset = 1'b1;
		cpu_bus = '0;
		dmc = '0;
		chr = '0;
		mem_din_cpu = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		// Quiet after reset, cpu_ce period
		wait_cpu_ce();
		repeat (3) begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
				assert (!pause_cpu && !dmc_ack) else begin
					errors++;
					$display("ERROR %0t: pause_cpu or dmc_ack high while idle", $time);
				end
			end while (!cpu_ce);
			assert (n == 12) else begin
				errors++;
				$display("ERROR %0t: cpu_ce period %0d, expected 12", $time, n);
			end
		end
		assert (log_q.size() == 0) else begin
			errors++;
			$display("ERROR %0t: memory strobes seen while idle", $time);
		end

		repeat (20) random_access();
		sprite_copy(1'b0);
		sprite_copy(1'b1);
		for (int i = 0; i < 20; i++)
			ppu_collision(i[0]);

		failures = uut.u_dma.dma_props.failures + uut.u_mem_mux.mux_props.failures;
		$display("Checks done: %0d testbench errors, %0d assertion failures", errors, failures);
		if (errors == 0 && failures == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog timeout: the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: all.f
verilog/nes_bus_pkg.sv
verilog/cpu_clock_divider.sv
verilog/dma_controller.sv
verilog/memory_multiplex.sv
verilog/nes_bus_top.sv
tests/nes_bus_properties.sv
tests/nes_bus_tb.sv

// File: Bender.yml
package:
  name: nes_bus

sources:
  - verilog/nes_bus_pkg.sv
  - verilog/cpu_clock_divider.sv
  - verilog/dma_controller.sv
  - verilog/memory_multiplex.sv
  - verilog/nes_bus_top.sv
  - target: test
    files:
      - tests/nes_bus_properties.sv
      - tests/nes_bus_tb.sv
